/* logic/board_cfg_pkg.sv */
package board_cfg_pkg;

  //////////////////////////////////////////////////
  // Register bus widths
  //////////////////////////////////////////////////

  // Byte address of one register
  localparam int unsigned RegAddrW = 8;

  // Data word of the register bus
  localparam int unsigned RegDataW = 32;

  //////////////////////////////////////////////////
  // Board timing and fan
  //////////////////////////////////////////////////

  // Duty setting from the board switches, one PWM period is 2**FanDutyW steps
  localparam int unsigned FanDutyW = 4;

  // 50 MHz soc_clk divided down to a 1 MHz RTC
  localparam int unsigned DefRtcDiv = 50;

  // soc_clk cycles per PWM step
  localparam int unsigned DefPwmPrescale = 4;

endpackage

/* logic/regbus_pkg.sv */
package regbus_pkg;

  //////////////////////////////////////////////////
  // Opcodes and register map
  //////////////////////////////////////////////////

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  // Word aligned register offsets
  typedef enum logic [board_cfg_pkg::RegAddrW-1:0] {
    REG_SCRATCH = 8'h00,
    REG_FAN_OVR = 8'h04,
    REG_UPTIME  = 8'h08,
    REG_ID      = 8'h0C
  } reg_addr_e;

  //////////////////////////////////////////////////
  // Fixed response words
  //////////////////////////////////////////////////

  // Returned on unmapped or illegal accesses
  localparam logic [board_cfg_pkg::RegDataW-1:0] ErrVal = 32'hBADCAB1E;

  localparam logic [board_cfg_pkg::RegDataW-1:0] ChipId = 32'h0B0A2D01;

endpackage

/* logic/reg_if.sv */
interface reg_if;

  // Request side, driven by the access FSM
  logic                                access;
  regbus_pkg::reg_op_e                 op;
  logic [board_cfg_pkg::RegAddrW-1:0]  addr;
  logic [board_cfg_pkg::RegDataW-1:0]  wdata;

  // Response side, registered in the bank and held until the next access
  logic [board_cfg_pkg::RegDataW-1:0]  rdata;
  logic                                error;

  modport ctrl (
    output access, op, addr, wdata,
    input  rdata, error
  );

  modport bank (
    input  access, op, addr, wdata,
    output rdata, error
  );

endinterface

/* logic/tick_timer.sv */
module tick_timer #(
  parameter int unsigned RtcDiv      = 50,
  parameter int unsigned PwmPrescale = 4
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o,
  output logic us_tick_o,
  output logic pwm_step_o
);

  // RTC level toggles every half period
  localparam int unsigned RtcHalf = RtcDiv / 2;
  localparam int unsigned RtcCntW = $clog2(RtcHalf + 1);
  localparam int unsigned PwmCntW = $clog2(PwmPrescale + 1);

  logic [RtcCntW-1:0] rtc_cnt_q;
  logic [PwmCntW-1:0] pwm_cnt_q;
  logic               rtc_wrap;
  logic               pwm_wrap;

  assign rtc_wrap = (rtc_cnt_q == RtcCntW'(RtcHalf - 1));
  assign pwm_wrap = (pwm_cnt_q == PwmCntW'(PwmPrescale - 1));

  //////////////////////////////////////////////////
  // RTC divider
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_cnt_q <= '0;
      rtc_o     <= 1'b0;
      us_tick_o <= 1'b0;
    end else begin
      rtc_cnt_q <= rtc_wrap ? '0 : rtc_cnt_q + 1'b1;
      if (rtc_wrap) begin
        rtc_o <= ~rtc_o;
      end
      // One pulse per RTC period, aligned with the rising level
      us_tick_o <= rtc_wrap & ~rtc_o;
    end
  end

  //////////////////////////////////////////////////
  // PWM prescaler
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt_q  <= '0;
      pwm_step_o <= 1'b0;
    end else begin
      pwm_cnt_q  <= pwm_wrap ? '0 : pwm_cnt_q + 1'b1;
      pwm_step_o <= pwm_wrap;
    end
  end

endmodule

/* logic/fan_pwm.sv */
module fan_pwm (
  input  logic                               soc_clk,
  input  logic                               rst_n,
  input  logic                               pwm_step_i,
  input  logic [board_cfg_pkg::FanDutyW-1:0] fan_sw_i,
  input  logic                               ovr_en_i,
  input  logic [board_cfg_pkg::FanDutyW-1:0] ovr_duty_i,
  output logic                               fan_pwm_o
);

  logic [board_cfg_pkg::FanDutyW-1:0] step_cnt_q;
  logic [board_cfg_pkg::FanDutyW-1:0] duty_q;
  logic [board_cfg_pkg::FanDutyW-1:0] duty_eff;
  logic                               period_end;

  // Register override wins over the switches
  assign duty_eff   = ovr_en_i ? ovr_duty_i : fan_sw_i;
  assign period_end = pwm_step_i & (&step_cnt_q);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      step_cnt_q <= '0;
      duty_q     <= '0;
    end else begin
      if (pwm_step_i) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
      // New duty only takes effect at a period start
      if (period_end) begin
        duty_q <= duty_eff;
      end
    end
  end

  // Glitch free output
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_pwm_o <= 1'b0;
    end else begin
      fan_pwm_o <= (step_cnt_q < duty_q);
    end
  end

endmodule

/* logic/reg_access_fsm.sv */
module reg_access_fsm (
  input  logic                               soc_clk,
  input  logic                               rst_n,
  input  logic                               valid_i,
  input  regbus_pkg::reg_op_e                op_i,
  input  logic [board_cfg_pkg::RegAddrW-1:0] addr_i,
  input  logic [board_cfg_pkg::RegDataW-1:0] wdata_i,
  output logic                               rsp_valid_o,
  output logic [board_cfg_pkg::RegDataW-1:0] rdata_o,
  output logic                               error_o,
  output logic                               busy_o,
  reg_if.ctrl                                bus
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } state_e;

  state_e state_q;
  state_e state_d;

  regbus_pkg::reg_op_e                op_q;
  logic [board_cfg_pkg::RegAddrW-1:0] addr_q;
  logic [board_cfg_pkg::RegDataW-1:0] wdata_q;

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (valid_i) begin
          state_d = ACCESS;
        end
      end
      ACCESS:  state_d = RESPOND;
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture, held through the access
  always_ff @(posedge soc_clk) begin
    if (state_q == IDLE && valid_i) begin
      op_q    <= op_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Bank side and response
  //////////////////////////////////////////////////

  assign bus.access = (state_q == ACCESS);
  assign bus.op     = op_q;
  assign bus.addr   = addr_q;
  assign bus.wdata  = wdata_q;

  // Requests seen while busy are dropped
  assign busy_o      = (state_q != IDLE);
  assign rsp_valid_o = (state_q == RESPOND);
  assign rdata_o     = bus.rdata;
  assign error_o     = bus.error;

endmodule

/* logic/board_regs.sv */
module board_regs (
  input  logic                               soc_clk,
  input  logic                               rst_n,
  input  logic                               us_tick_i,
  reg_if.bank                                bus,
  output logic                               fan_ovr_en_o,
  output logic [board_cfg_pkg::FanDutyW-1:0] fan_ovr_duty_o
);

  localparam int unsigned DataW = board_cfg_pkg::RegDataW;
  localparam int unsigned DutyW = board_cfg_pkg::FanDutyW;

  logic [DataW-1:0] scratch_q;
  logic [DataW-1:0] uptime_q;
  logic [DataW-1:0] rd_val;
  logic             rd_err;
  logic             wr_scratch;
  logic             wr_fan;
  logic             is_write;

  assign is_write = (bus.op == regbus_pkg::REG_WRITE);

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  always_comb begin
    rd_val     = regbus_pkg::ErrVal;
    rd_err     = 1'b0;
    wr_scratch = 1'b0;
    wr_fan     = 1'b0;
    case (bus.addr)
      regbus_pkg::REG_SCRATCH: begin
        rd_val     = scratch_q;
        wr_scratch = is_write;
      end
      regbus_pkg::REG_FAN_OVR: begin
        rd_val = DataW'({fan_ovr_en_o, fan_ovr_duty_o});
        wr_fan = is_write;
      end
      regbus_pkg::REG_UPTIME: rd_val = uptime_q;
      regbus_pkg::REG_ID:     rd_val = regbus_pkg::ChipId;
      default:                rd_err = 1'b1;
    endcase
    // Read-only registers reject writes
    if (is_write && (bus.addr == regbus_pkg::REG_UPTIME || bus.addr == regbus_pkg::REG_ID)) begin
      rd_err = 1'b1;
    end
    if (rd_err) begin
      rd_val = regbus_pkg::ErrVal;
    end
  end

  //////////////////////////////////////////////////
  // Register state
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q      <= '0;
      fan_ovr_en_o   <= 1'b0;
      fan_ovr_duty_o <= '0;
      uptime_q       <= '0;
      bus.error      <= 1'b0;
    end else begin
      if (bus.access && wr_scratch) begin
        scratch_q <= bus.wdata;
      end
      if (bus.access && wr_fan) begin
        fan_ovr_en_o   <= bus.wdata[DutyW];
        fan_ovr_duty_o <= bus.wdata[DutyW-1:0];
      end
      if (us_tick_i) begin
        uptime_q <= uptime_q + 1'b1;
      end
      if (bus.access) begin
        bus.error <= rd_err;
      end
    end
  end

  // Read data held until the next access
  always_ff @(posedge soc_clk) begin
    if (bus.access) begin
      bus.rdata <= rd_val;
    end
  end

endmodule

/* logic/board_ctrl_top.sv */
module board_ctrl_top #(
  parameter int unsigned RtcDiv      = board_cfg_pkg::DefRtcDiv,
  parameter int unsigned PwmPrescale = board_cfg_pkg::DefPwmPrescale
) (
  input  logic                               soc_clk,
  input  logic                               rst_n,
  input  logic [board_cfg_pkg::FanDutyW-1:0] fan_sw_i,
  output logic                               fan_pwm_o,
  output logic                               rtc_o,
  input  logic                               reg_valid_i,
  input  regbus_pkg::reg_op_e                reg_op_i,
  input  logic [board_cfg_pkg::RegAddrW-1:0] reg_addr_i,
  input  logic [board_cfg_pkg::RegDataW-1:0] reg_wdata_i,
  output logic                               reg_rsp_valid_o,
  output logic [board_cfg_pkg::RegDataW-1:0] reg_rdata_o,
  output logic                               reg_error_o,
  output logic                               reg_busy_o
);

  logic                               us_tick;
  logic                               pwm_step;
  logic                               fan_ovr_en;
  logic [board_cfg_pkg::FanDutyW-1:0] fan_ovr_duty;

  reg_if bank_bus ();

  //////////////////////////////////////////////////
  // Timing and fan
  //////////////////////////////////////////////////

  tick_timer #(
    .RtcDiv      ( RtcDiv      ),
    .PwmPrescale ( PwmPrescale )
  ) u_tick_timer (
    .soc_clk    ( soc_clk  ),
    .rst_n      ( rst_n    ),
    .rtc_o      ( rtc_o    ),
    .us_tick_o  ( us_tick  ),
    .pwm_step_o ( pwm_step )
  );

  fan_pwm u_fan_pwm (
    .soc_clk    ( soc_clk      ),
    .rst_n      ( rst_n        ),
    .pwm_step_i ( pwm_step     ),
    .fan_sw_i   ( fan_sw_i     ),
    .ovr_en_i   ( fan_ovr_en   ),
    .ovr_duty_i ( fan_ovr_duty ),
    .fan_pwm_o  ( fan_pwm_o    )
  );

  //////////////////////////////////////////////////
  // Register access
  //////////////////////////////////////////////////

  reg_access_fsm u_reg_access_fsm (
    .soc_clk     ( soc_clk         ),
    .rst_n       ( rst_n           ),
    .valid_i     ( reg_valid_i     ),
    .op_i        ( reg_op_i        ),
    .addr_i      ( reg_addr_i      ),
    .wdata_i     ( reg_wdata_i     ),
    .rsp_valid_o ( reg_rsp_valid_o ),
    .rdata_o     ( reg_rdata_o     ),
    .error_o     ( reg_error_o     ),
    .busy_o      ( reg_busy_o      ),
    .bus         ( bank_bus        )
  );

  board_regs u_board_regs (
    .soc_clk        ( soc_clk      ),
    .rst_n          ( rst_n        ),
    .us_tick_i      ( us_tick      ),
    .bus            ( bank_bus     ),
    .fan_ovr_en_o   ( fan_ovr_en   ),
    .fan_ovr_duty_o ( fan_ovr_duty )
  );

endmodule

/* verif/tb_board_ctrl_top.sv */
module tb_board_ctrl_top;

  localparam int unsigned ClkPeriod    = 100;
  localparam int unsigned ResetCycles  = 16;
  localparam int unsigned Seed         = 43371;
  localparam int unsigned RtcDiv       = board_cfg_pkg::DefRtcDiv;
  localparam int unsigned PwmPrescale  = board_cfg_pkg::DefPwmPrescale;
  localparam int unsigned PwmPeriod    = 16 * PwmPrescale;
  localparam int unsigned UptimeTicks  = 3;
  localparam int unsigned MaxLatency   = 8;
  localparam int unsigned AccessCycles = 8;
  // 13 accesses, two RTC measurements, six fan measurements and some slack
  localparam int unsigned WatchdogCycles = ResetCycles + 13 * AccessCycles + 3 * RtcDiv
                                         + UptimeTicks * RtcDiv + 6 * (2 * PwmPeriod + 2) + 500;

  typedef logic [board_cfg_pkg::RegDataW-1:0] data_t;
  typedef logic [board_cfg_pkg::RegAddrW-1:0] addr_t;
  typedef logic [board_cfg_pkg::FanDutyW-1:0] duty_t;

  logic                soc_clk;
  logic                rst_n;
  duty_t               fan_sw_i;
  logic                fan_pwm_o;
  logic                rtc_o;
  logic                reg_valid_i;
  regbus_pkg::reg_op_e reg_op_i;
  addr_t               reg_addr_i;
  data_t               reg_wdata_i;
  logic                reg_rsp_valid_o;
  data_t               reg_rdata_o;
  logic                reg_error_o;
  logic                reg_busy_o;

  int unsigned data_errs;
  int unsigned flag_errs;
  int unsigned count_errs;
  int unsigned level_errs;
  int unsigned proto_errs;
  // Time of the last request sampling edge
  time         req_time;

  board_ctrl_top #(
    .RtcDiv      ( RtcDiv      ),
    .PwmPrescale ( PwmPrescale )
  ) u_board_ctrl_top (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .fan_sw_i        ( fan_sw_i        ),
    .fan_pwm_o       ( fan_pwm_o       ),
    .rtc_o           ( rtc_o           ),
    .reg_valid_i     ( reg_valid_i     ),
    .reg_op_i        ( reg_op_i        ),
    .reg_addr_i      ( reg_addr_i      ),
    .reg_wdata_i     ( reg_wdata_i     ),
    .reg_rsp_valid_o ( reg_rsp_valid_o ),
    .reg_rdata_o     ( reg_rdata_o     ),
    .reg_error_o     ( reg_error_o     ),
    .reg_busy_o      ( reg_busy_o      )
  );

  initial begin
    soc_clk = 1'b0;
    forever #(ClkPeriod / 2) soc_clk = ~soc_clk;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge soc_clk);
    $display("ERROR: watchdog expired after %0d cycles, the run is stuck", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_error(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      flag_errs++;
    end
  endtask

  task automatic check_count(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      count_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      level_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // Bus and measurement helpers
  //////////////////////////////////////////////////

  function automatic bit is_mapped(input addr_t addr);
    return addr == regbus_pkg::REG_SCRATCH || addr == regbus_pkg::REG_FAN_OVR ||
           addr == regbus_pkg::REG_UPTIME  || addr == regbus_pkg::REG_ID;
  endfunction

  // One request, then wait for the strobe and count cycles after the request edge
  task automatic reg_access(input regbus_pkg::reg_op_e op, input addr_t addr,
                            input data_t wdata, output data_t rdata,
                            output logic error, output int unsigned latency);
    logic got_rsp;
    rdata   = '0;
    error   = 1'b0;
    latency = 0;
    got_rsp = 1'b0;
    @(negedge soc_clk);
    while (reg_busy_o) begin
      @(negedge soc_clk);
    end
    @(posedge soc_clk);
    reg_valid_i <= 1'b1;
    reg_op_i    <= op;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    @(posedge soc_clk);
    req_time    = $time;
    reg_valid_i <= 1'b0;
    while (!got_rsp && latency < MaxLatency) begin
      if (latency > 0) begin
        @(posedge soc_clk);
      end
      latency++;
      @(negedge soc_clk);
      got_rsp = reg_rsp_valid_o;
      if (latency <= 2 && reg_busy_o !== 1'b1) begin
        $display("ERROR: reg_busy_o was low during the access to address 0x%h", addr);
        proto_errs++;
      end
    end
    if (!got_rsp) begin
      $display("ERROR: no response strobe for the access to address 0x%h", addr);
      proto_errs++;
    end else begin
      rdata = reg_rdata_o;
      error = reg_error_o;
      @(posedge soc_clk);
      @(negedge soc_clk);
      if (reg_rsp_valid_o) begin
        $display("ERROR: response strobe for address 0x%h lasted more than one cycle", addr);
        proto_errs++;
      end
    end
  endtask

  task automatic measure_rtc_period(output int unsigned period);
    logic        prev;
    int unsigned n;
    int unsigned rise_at[$];
    period = 0;
    @(negedge soc_clk);
    prev = rtc_o;
    for (n = 1; n <= 3 * RtcDiv && rise_at.size() < 2; n++) begin
      @(negedge soc_clk);
      if (rtc_o && !prev) begin
        rise_at.push_back(n);
      end
      prev = rtc_o;
    end
    if (rise_at.size() < 2) begin
      $display("ERROR: rtc_o did not rise twice within %0d cycles", 3 * RtcDiv);
      proto_errs++;
    end else begin
      period = rise_at[1] - rise_at[0];
    end
  endtask

  // Settle one PWM period, then count high cycles over the next one
  task automatic measure_fan_high(output int unsigned high);
    high = 0;
    repeat (PwmPeriod + 1) @(posedge soc_clk);
    repeat (PwmPeriod) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        high++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_and_latency();
    data_t       rdata;
    logic        err;
    int unsigned lat;
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_ID, '0, rdata, err, lat);
    check_data("reg_rdata_o (REG_ID)", rdata, regbus_pkg::ChipId);
    check_error("reg_error_o (REG_ID)", err, 1'b0);
    check_count("response latency", lat, 2);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_SCRATCH, '0, rdata, err, lat);
    check_data("reg_rdata_o (scratch after reset)", rdata, '0);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_FAN_OVR, '0, rdata, err, lat);
    check_data("reg_rdata_o (fan override after reset)", rdata, '0);
  endtask

  task automatic scratch_readback();
    data_t       wdata;
    data_t       rdata;
    logic        err;
    int unsigned lat;
    wdata = $urandom();
    reg_access(regbus_pkg::REG_WRITE, regbus_pkg::REG_SCRATCH, wdata, rdata, err, lat);
    check_error("reg_error_o (scratch write)", err, 1'b0);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_SCRATCH, '0, rdata, err, lat);
    check_data("reg_rdata_o (scratch)", rdata, wdata);
    check_error("reg_error_o (scratch read)", err, 1'b0);
  endtask

  task automatic error_responses();
    addr_t       bad_addr;
    data_t       rdata;
    logic        err;
    int unsigned lat;
    do begin
      bad_addr = addr_t'($urandom());
    end while (is_mapped(bad_addr));
    reg_access(regbus_pkg::REG_READ, bad_addr, '0, rdata, err, lat);
    check_data("reg_rdata_o (unmapped)", rdata, regbus_pkg::ErrVal);
    check_error("reg_error_o (unmapped)", err, 1'b1);
    reg_access(regbus_pkg::REG_WRITE, regbus_pkg::REG_ID, $urandom(), rdata, err, lat);
    check_data("reg_rdata_o (REG_ID write)", rdata, regbus_pkg::ErrVal);
    check_error("reg_error_o (REG_ID write)", err, 1'b1);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_ID, '0, rdata, err, lat);
    check_data("reg_rdata_o (REG_ID after write)", rdata, regbus_pkg::ChipId);
    check_error("reg_error_o (REG_ID after write)", err, 1'b0);
  endtask

  task automatic rtc_and_uptime();
    int unsigned period;
    int unsigned spacing;
    data_t       up_a;
    data_t       up_b;
    logic        err;
    int unsigned lat;
    time         t_a;
    measure_rtc_period(period);
    check_count("rtc_o period in cycles", period, RtcDiv);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_UPTIME, '0, up_a, err, lat);
    t_a = req_time;
    // Second request edge lands UptimeTicks RTC periods after the first
    repeat (UptimeTicks * RtcDiv - 4) @(posedge soc_clk);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_UPTIME, '0, up_b, err, lat);
    spacing = 32'((req_time - t_a) / ClkPeriod);
    check_count("uptime read spacing in cycles", spacing, UptimeTicks * RtcDiv);
    check_data("uptime difference", up_b - up_a, data_t'(UptimeTicks));
  endtask

  task automatic fan_from_switches();
    duty_t       duties[4] = '{4'd0, 4'd5, 4'd10, 4'd15};
    int unsigned high;
    foreach (duties[i]) begin
      @(posedge soc_clk);
      fan_sw_i <= duties[i];
      measure_fan_high(high);
      check_count($sformatf("fan_pwm_o high cycles, fan_sw_i=%0d", duties[i]), high,
                  32'(duties[i]) * PwmPrescale);
    end
  endtask

  task automatic fan_override();
    duty_t       sw_duty;
    duty_t       ovr_duty;
    data_t       rdata;
    logic        err;
    int unsigned lat;
    int unsigned high;
    sw_duty  = 4'd12;
    ovr_duty = 4'd3;
    @(posedge soc_clk);
    fan_sw_i <= sw_duty;
    // Bit 4 enables the override
    reg_access(regbus_pkg::REG_WRITE, regbus_pkg::REG_FAN_OVR, data_t'({1'b1, ovr_duty}),
               rdata, err, lat);
    check_error("reg_error_o (fan override write)", err, 1'b0);
    reg_access(regbus_pkg::REG_READ, regbus_pkg::REG_FAN_OVR, '0, rdata, err, lat);
    check_data("reg_rdata_o (fan override)", rdata, data_t'({1'b1, ovr_duty}));
    measure_fan_high(high);
    check_count("fan_pwm_o high cycles, override on", high, 32'(ovr_duty) * PwmPrescale);
    reg_access(regbus_pkg::REG_WRITE, regbus_pkg::REG_FAN_OVR, data_t'({1'b0, ovr_duty}),
               rdata, err, lat);
    measure_fan_high(high);
    check_count("fan_pwm_o high cycles, override off", high, 32'(sw_duty) * PwmPrescale);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned total;
    void'($urandom(Seed));
    rst_n       = 1'b0;
    fan_sw_i    = '0;
    reg_valid_i = 1'b0;
    reg_op_i    = regbus_pkg::REG_READ;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    req_time    = 0;
    data_errs   = 0;
    flag_errs   = 0;
    count_errs  = 0;
    level_errs  = 0;
    proto_errs  = 0;
    repeat (ResetCycles) @(posedge soc_clk);
    rst_n <= 1'b1;
    @(negedge soc_clk);
    check_level("reg_rsp_valid_o after reset", reg_rsp_valid_o, 1'b0);
    check_level("reg_busy_o after reset", reg_busy_o, 1'b0);
    check_error("reg_error_o after reset", reg_error_o, 1'b0);
    check_level("rtc_o after reset", rtc_o, 1'b0);
    check_level("fan_pwm_o after reset", fan_pwm_o, 1'b0);
    reset_and_latency();
    scratch_readback();
    error_responses();
    rtc_and_uptime();
    fan_from_switches();
    fan_override();
    total = data_errs + flag_errs + count_errs + level_errs + proto_errs;
    $display("Errors: data %0d, error bit %0d, cycle count %0d, level %0d, protocol %0d",
             data_errs, flag_errs, count_errs, level_errs, proto_errs);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* board_ctrl_top.f */
logic/board_cfg_pkg.sv
logic/regbus_pkg.sv
logic/reg_if.sv
logic/tick_timer.sv
logic/fan_pwm.sv
logic/reg_access_fsm.sv
logic/board_regs.sv
logic/board_ctrl_top.sv
verif/tb_board_ctrl_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the board_ctrl_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=sim_board_ctrl
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_board_ctrl_top \
  -f board_ctrl_top.f \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
